// ==== Makefile ====
TOP = tbDzcpuUcode
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --assert -f dzcpuUcode.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f dzcpuUcode.f \
		--top-module $(TOP) -o simv
	./obj_dir/simv +verilator+error+limit+100 | tee $(LOG)
	grep -q "^ALL CHECKS PASSED$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== dzcpuFlowLut.sv ====
`timescale 1ns/1ps
`include "dzcpuUcode_params.svh"

module dzcpuFlowLut
(
	input  logic [7:0]             opcode,
	input  logic                   cbPage,
	output logic [`UOP_ADDR_W-1:0] flowAddr
);

	//////////////////////////////////////////////////////////////////////
	// Opcode to flow start address
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		if (cbPage)
		begin
			// Second byte of a CB prefixed instruction
			case (opcode)
				`CB_BIT7H: flowAddr = 7'd62;
				`CB_RLC:   flowAddr = 7'd63;
				default:   flowAddr = 7'd0;
			endcase
		end
		else
		begin
			case (opcode)
				`OP_NOP:    flowAddr = 7'd1;
				// Immediate loads
				`OP_LDBN:   flowAddr = 7'd2;
				`OP_LDCN:   flowAddr = 7'd5;
				`OP_LDAN:   flowAddr = 7'd8;
				// Single word ALU ops
				`OP_INCB:   flowAddr = 7'd11;
				`OP_DECB:   flowAddr = 7'd12;
				`OP_INCC:   flowAddr = 7'd13;
				`OP_DECC:   flowAddr = 7'd14;
				`OP_INCA:   flowAddr = 7'd15;
				`OP_DECA:   flowAddr = 7'd16;
				// Accumulator arithmetic
				`OP_ADDB:   flowAddr = 7'd17;
				`OP_ADDC:   flowAddr = 7'd20;
				`OP_SUBB:   flowAddr = 7'd23;
				`OP_SUBC:   flowAddr = 7'd26;
				// Stack
				`OP_PUSHBC: flowAddr = 7'd29;
				`OP_POPBC:  flowAddr = 7'd35;
				// Relative jumps
				`OP_JRN:    flowAddr = 7'd41;
				`OP_JRNZ:   flowAddr = 7'd47;
				`OP_JRZ:    flowAddr = 7'd53;
				`OP_CB:     flowAddr = 7'd59;
				// Anything else runs the generic one byte flow
				default:    flowAddr = 7'd0;
			endcase
		end
	end

endmodule

// ==== dzcpuUcode.f ====
+incdir+.
dzcpuUcodePkg.sv
dzcpuFlowLut.sv
dzcpuUcodeRom.sv
dzcpuUcodeSeq.sv
dzcpuUcode.sv
dzcpuUcode_chk.sv
tbDzcpuUcode.sv

// ==== dzcpuUcode.sv ====
`timescale 1ns/1ps
`include "dzcpuUcode_params.svh"

module dzcpuUcode
(
	input  logic               Clock,
	input  logic               rst,
	input  logic [7:0]         opcode,
	input  logic               opValid,
	output logic               opReady,
	input  logic               zeroFlag,
	output dzcpuUcodePkg::uopT uop,
	output logic               uopValid,
	input  logic               uopReady
);
	import dzcpuUcodePkg::*;

	logic [7:0]             lutOpcode;
	logic                   cbPage;
	logic [`UOP_ADDR_W-1:0] flowAddr;
	logic [`UOP_ADDR_W-1:0] romAddr;
	uopT                    romWord;

	// Opcode to flow start
	dzcpuFlowLut uFlowLut
	(
		.opcode   (lutOpcode),
		.cbPage   (cbPage),
		.flowAddr (flowAddr)
	);

	dzcpuUcodeRom uRom
	(
		.addr (romAddr),
		.word (romWord)
	);

	dzcpuUcodeSeq uSeq
	(
		.Clock     (Clock),
		.rst       (rst),
		.opcode    (opcode),
		.opValid   (opValid),
		.opReady   (opReady),
		.zeroFlag  (zeroFlag),
		.uop       (uop),
		.uopValid  (uopValid),
		.uopReady  (uopReady),
		.lutOpcode (lutOpcode),
		.cbPage    (cbPage),
		.flowAddr  (flowAddr),
		.romAddr   (romAddr),
		.romWord   (romWord)
	);

endmodule

// ==== dzcpuUcodePkg.sv ====
`include "dzcpuUcode_params.svh"

package dzcpuUcodePkg;

	//////////////////////////////////////////////////////////////////////
	// Microword fields
	//////////////////////////////////////////////////////////////////////

	// What the sequencer does once a word is consumed
	typedef enum logic [`UOP_END_W-1:0]
	{
		op       = 4'd0,
		inc      = 4'd1,
		eof      = 4'd2,
		incEof   = 4'd3,
		eofFu    = 4'd4,
		incEofFu = 4'd5,
		updFlags = 4'd6,
		incEofZ  = 4'd7,
		incEofNz = 4'd8
	} endClassT;

	// Datapath operation
	typedef enum logic [`UOP_OP_W-1:0]
	{
		nop     = 5'd0,
		sma     = 5'd1,
		smw     = 5'd2,
		srm     = 5'd3,
		inc16   = 5'd4,
		dec16   = 5'd5,
		sx16r   = 5'd6,
		srx16   = 5'd7,
		addx16  = 5'd8,
		subx16  = 5'd9,
		spc     = 5'd10,
		jcb     = 5'd11,
		bitOp   = 5'd12,
		shl     = 5'd13,
		z801bop = 5'd14
	} uopOpT;

	// Register or temp the operation acts on
	typedef enum logic [`UOP_OPND_W-1:0]
	{
		a    = 5'd0,
		b    = 5'd1,
		c    = 5'd2,
		h    = 5'd3,
		l    = 5'd4,
		sp   = 5'd5,
		pc   = 5'd6,
		x8   = 5'd7,
		x16  = 5'd8,
		none = 5'd9
	} operandT;

	typedef struct packed
	{
		endClassT endClass;
		uopOpT    op;
		operandT  operand;
	} uopT;

endpackage

// ==== dzcpuUcodeRom.sv ====
`timescale 1ns/1ps
`include "dzcpuUcode_params.svh"

module dzcpuUcodeRom
(
	input  logic [`UOP_ADDR_W-1:0] addr,
	output dzcpuUcodePkg::uopT     word
);
	import dzcpuUcodePkg::*;

	localparam int romIdxW = $clog2(`UOP_ROM_DEPTH);

	// Returned for addresses past the last flow
	localparam uopT idleWord = '{op, nop, none};

	//////////////////////////////////////////////////////////////////////
	// Flow storage
	//////////////////////////////////////////////////////////////////////
	localparam uopT romTable [`UOP_ROM_DEPTH] = '{
		// Generic one byte op (0)
		'{incEof, z801bop, a},
		// NOP (1)
		'{incEof, nop, none},
		// LD B,n (2)
		'{inc, sma, pc}, '{inc, nop, none}, '{eof, srm, b},
		// LD C,n (5)
		'{inc, sma, pc}, '{inc, nop, none}, '{eof, srm, c},
		// LD A,n (8)
		'{inc, sma, pc}, '{inc, nop, none}, '{eof, srm, a},
		// INC/DEC of B, C, A (11..16)
		'{incEofFu, inc16, b}, '{incEofFu, dec16, b},
		'{incEofFu, inc16, c}, '{incEofFu, dec16, c},
		'{incEofFu, inc16, a}, '{incEofFu, dec16, a},
		// ADD A,B (17)
		'{op, sx16r, a}, '{updFlags, addx16, b}, '{incEof, srx16, a},
		// ADD A,C (20)
		'{op, sx16r, a}, '{updFlags, addx16, c}, '{incEof, srx16, a},
		// SUB B (23)
		'{op, sx16r, a}, '{updFlags, subx16, b}, '{incEof, srx16, a},
		// SUB C (26)
		'{op, sx16r, a}, '{updFlags, subx16, c}, '{incEof, srx16, a},
		// PUSH BC (29)
		'{op, dec16, sp}, '{op, sma, sp}, '{op, smw, b},
		'{op, dec16, sp}, '{op, smw, c}, '{incEof, sma, pc},
		// POP BC (35)
		'{op, sma, sp}, '{op, inc16, sp}, '{op, srm, c},
		'{op, srm, b}, '{inc, inc16, sp}, '{eof, sma, pc},
		// JR n (41)
		'{inc, sma, pc}, '{op, nop, none}, '{inc, srm, x8},
		'{op, sx16r, pc}, '{op, addx16, x8}, '{eof, spc, x16},
		// JR NZ,n (47) bails out on word 3 when Z is set
		'{inc, sma, pc}, '{op, nop, none}, '{incEofZ, srm, x8},
		'{op, sx16r, pc}, '{op, addx16, x8}, '{eof, spc, x16},
		// JR Z,n (53)
		'{inc, sma, pc}, '{op, nop, none}, '{incEofNz, srm, x8},
		'{op, sx16r, pc}, '{op, addx16, x8}, '{eof, spc, x16},
		// CB prefix (59) then wait for the second byte
		'{inc, sma, pc}, '{op, nop, none}, '{inc, jcb, none},
		// BIT 7,H (62)
		'{eofFu, bitOp, none},
		// RL C (63)
		'{eofFu, shl, c}
	};

	logic               inRange;
	logic [romIdxW-1:0] romIdx;

	assign inRange = ~|addr[`UOP_ADDR_W-1:romIdxW];
	assign romIdx  = addr[romIdxW-1:0];
	assign word    = inRange ? romTable[romIdx] : idleWord;

endmodule

// ==== dzcpuUcodeSeq.sv ====
`timescale 1ns/1ps
`include "dzcpuUcode_params.svh"

module dzcpuUcodeSeq
(
	input  logic                   Clock,
	input  logic                   rst,
	input  logic [7:0]             opcode,
	input  logic                   opValid,
	output logic                   opReady,
	input  logic                   zeroFlag,
	output dzcpuUcodePkg::uopT     uop,
	output logic                   uopValid,
	input  logic                   uopReady,
	output logic [7:0]             lutOpcode,
	output logic                   cbPage,
	input  logic [`UOP_ADDR_W-1:0] flowAddr,
	output logic [`UOP_ADDR_W-1:0] romAddr,
	input  dzcpuUcodePkg::uopT     romWord
);
	import dzcpuUcodePkg::*;

	typedef enum logic [1:0]
	{
		stIdle,
		stStream,
		stCbWait
	} seqStateT;

	seqStateT               state;
	logic [7:0]             opReg;
	logic                   zReg;
	logic [`UOP_ADDR_W-1:0] addrReg;
	uopT                    uopReg;

	logic opTaken;
	logic uopTaken;
	logic flowEnds;
	logic cbJump;

	//////////////////////////////////////////////////////////////////////
	// Handshakes and lookups
	//////////////////////////////////////////////////////////////////////

	assign opReady  = (state == stIdle) || (state == stCbWait);
	assign uopValid = (state == stStream);
	assign uop      = uopReg;
	assign opTaken  = opValid && opReady;
	assign uopTaken = uopValid && uopReady;

	// Table sees the live byte only while one can be taken
	assign lutOpcode = opReady ? opcode : opReg;
	assign cbPage    = (state == stCbWait);
	assign romAddr   = opReady ? flowAddr : addrReg;

	// Decode of the word being handed out
	always_comb
	begin
		case (uopReg.endClass)
			eof, incEof, eofFu, incEofFu: flowEnds = 1'b1;
			incEofZ:  flowEnds = zReg;
			incEofNz: flowEnds = ~zReg;
			default:  flowEnds = 1'b0;
		endcase
	end

	assign cbJump = (uopReg.op == jcb);

	//////////////////////////////////////////////////////////////////////
	// Control
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge Clock)
	begin
		if (rst)
			state <= stIdle;
		else if (opTaken)
			state <= stStream;
		else if (uopTaken)
		begin
			if (cbJump)
				state <= stCbWait;
			else if (flowEnds)
				state <= stIdle;
		end
	end

	// Word register and next address
	always_ff @(posedge Clock)
	begin
		if (opTaken)
		begin
			opReg   <= opcode;
			zReg    <= zeroFlag;
			uopReg  <= romWord;
			addrReg <= flowAddr + 1'b1;
		end
		else if (uopTaken && !cbJump && !flowEnds)
		begin
			uopReg  <= romWord;
			addrReg <= addrReg + 1'b1;
		end
	end

endmodule

// ==== dzcpuUcode_chk.sv ====
`timescale 1ns/1ps

module dzcpuUcode_chk
(
	input logic               Clock,
	input logic               rst,
	input logic               opReady,
	input logic               uopValid,
	input logic               uopReady,
	input dzcpuUcodePkg::uopT uop
);

	int failCount = 0;

	// Stalled word must not move
	holdUop: assert property (@(posedge Clock) disable iff (rst)
		(uopValid && !uopReady) |=> ($stable(uop) && uopValid))
	else
	begin
		failCount++;
		$error("uop changed while stalled");
	end

	// Sequencer is either taking bytes or streaming words
	oneSide: assert property (@(posedge Clock) disable iff (rst)
		!(opReady && uopValid))
	else
	begin
		failCount++;
		$error("opReady and uopValid high together");
	end

	resetIdle: assert property (@(posedge Clock) rst |=> !uopValid)
	else
	begin
		failCount++;
		$error("uopValid high right after reset");
	end

endmodule

// ==== dzcpuUcode_params.svh ====
`ifndef DZCPU_UCODE_PARAMS_SVH
`define DZCPU_UCODE_PARAMS_SVH

// Microword field widths
`define UOP_END_W     4
`define UOP_OP_W      5
`define UOP_OPND_W    5

// Microcode ROM addressing
`define UOP_ADDR_W    7
`define UOP_ROM_DEPTH 64

//////////////////////////////////////////////////////////////////////
// Main page opcodes
//////////////////////////////////////////////////////////////////////
`define OP_NOP     8'h00
`define OP_LDBN    8'h06
`define OP_LDCN    8'h0E
`define OP_LDAN    8'h3E
`define OP_INCB    8'h04
`define OP_DECB    8'h05
`define OP_INCC    8'h0C
`define OP_DECC    8'h0D
`define OP_INCA    8'h3C
`define OP_DECA    8'h3D
`define OP_ADDB    8'h80
`define OP_ADDC    8'h81
`define OP_SUBB    8'h90
`define OP_SUBC    8'h91
`define OP_PUSHBC  8'hC5
`define OP_POPBC   8'hC1
`define OP_JRN     8'h18
`define OP_JRNZ    8'h20
`define OP_JRZ     8'h28
`define OP_CB      8'hCB

// Second byte after the CB prefix
`define CB_BIT7H   8'h7C
`define CB_RLC     8'h11

`endif

// ==== tbDzcpuUcode.sv ====
`timescale 1ns/1ps
`include "dzcpuUcode_params.svh"

module tbDzcpuUcode;
	import dzcpuUcodePkg::*;

	typedef uopT uopQueueT [$];

	logic       Clock;
	logic       rst;
	logic [7:0] opcode;
	logic       opValid;
	logic       opReady;
	logic       zeroFlag;
	uopT        uop;
	logic       uopValid;
	logic       uopReady;

	int         seed = 32'h4627b2c6;
	logic       randomReady = 1'b0;
	int         opsSent = 0;
	int         cycles = 0;
	uopQueueT   expQ;
	logic       lastQ [$];
	logic       endPending = 1'b0;
	logic       endExpected = 1'b0;
	logic       takePending = 1'b0;

	// Every single byte opcode with a flow of its own
	logic [7:0] mainOps [19] = '{`OP_NOP, `OP_LDBN, `OP_LDCN, `OP_LDAN, `OP_INCB, `OP_DECB,
		`OP_INCC, `OP_DECC, `OP_INCA, `OP_DECA, `OP_ADDB, `OP_ADDC, `OP_SUBB, `OP_SUBC,
		`OP_PUSHBC, `OP_POPBC, `OP_JRN, `OP_JRNZ, `OP_JRZ};

	dzcpuUcode u_dzcpuUcode
	(
		.Clock    (Clock),
		.rst      (rst),
		.opcode   (opcode),
		.opValid  (opValid),
		.opReady  (opReady),
		.zeroFlag (zeroFlag),
		.uop      (uop),
		.uopValid (uopValid),
		.uopReady (uopReady)
	);

	bind dzcpuUcode dzcpuUcode_chk uChk
	(
		.Clock    (Clock),
		.rst      (rst),
		.opReady  (opReady),
		.uopValid (uopValid),
		.uopReady (uopReady),
		.uop      (uop)
	);

	//////////////////////////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////////////////////////

	function automatic uopT makeUop(input endClassT e, input uopOpT o, input operandT r);
		uopT u;
		u.endClass = e;
		u.op       = o;
		u.operand  = r;
		return u;
	endfunction

	// Immediate byte fetch, then the register write
	function automatic uopQueueT ldFlow(input operandT r);
		uopQueueT f;
		f.push_back(makeUop(inc, sma, pc));
		f.push_back(makeUop(inc, nop, none));
		f.push_back(makeUop(eof, srm, r));
		return f;
	endfunction

	// A op r through the 16 bit temp
	function automatic uopQueueT aluFlow(input uopOpT o, input operandT r);
		uopQueueT f;
		f.push_back(makeUop(op, sx16r, a));
		f.push_back(makeUop(updFlags, o, r));
		f.push_back(makeUop(incEof, srx16, a));
		return f;
	endfunction

	// Cut short after the offset fetch when the condition fails
	function automatic uopQueueT jrFlow(input endClassT cls, input logic z);
		uopQueueT f;
		f.push_back(makeUop(inc, sma, pc));
		f.push_back(makeUop(op, nop, none));
		f.push_back(makeUop(cls, srm, x8));
		if (!((cls == incEofZ && z) || (cls == incEofNz && !z)))
		begin
			f.push_back(makeUop(op, sx16r, pc));
			f.push_back(makeUop(op, addx16, x8));
			f.push_back(makeUop(eof, spc, x16));
		end
		return f;
	endfunction

	function automatic uopQueueT expectFlow(input logic cb, input logic [7:0] code,
		input logic z);
		uopQueueT f;
		if (cb)
		begin
			case (code)
				`CB_BIT7H: f.push_back(makeUop(eofFu, bitOp, none));
				`CB_RLC:   f.push_back(makeUop(eofFu, shl, c));
				default:   f.push_back(makeUop(incEof, z801bop, a));
			endcase
		end
		else
		begin
			case (code)
				`OP_NOP:  f.push_back(makeUop(incEof, nop, none));
				`OP_LDBN: f = ldFlow(b);
				`OP_LDCN: f = ldFlow(c);
				`OP_LDAN: f = ldFlow(a);
				`OP_INCB: f.push_back(makeUop(incEofFu, inc16, b));
				`OP_DECB: f.push_back(makeUop(incEofFu, dec16, b));
				`OP_INCC: f.push_back(makeUop(incEofFu, inc16, c));
				`OP_DECC: f.push_back(makeUop(incEofFu, dec16, c));
				`OP_INCA: f.push_back(makeUop(incEofFu, inc16, a));
				`OP_DECA: f.push_back(makeUop(incEofFu, dec16, a));
				`OP_ADDB: f = aluFlow(addx16, b);
				`OP_ADDC: f = aluFlow(addx16, c);
				`OP_SUBB: f = aluFlow(subx16, b);
				`OP_SUBC: f = aluFlow(subx16, c);
				`OP_PUSHBC:
				begin
					f.push_back(makeUop(op, dec16, sp));
					f.push_back(makeUop(op, sma, sp));
					f.push_back(makeUop(op, smw, b));
					f.push_back(makeUop(op, dec16, sp));
					f.push_back(makeUop(op, smw, c));
					f.push_back(makeUop(incEof, sma, pc));
				end
				`OP_POPBC:
				begin
					f.push_back(makeUop(op, sma, sp));
					f.push_back(makeUop(op, inc16, sp));
					f.push_back(makeUop(op, srm, c));
					f.push_back(makeUop(op, srm, b));
					f.push_back(makeUop(inc, inc16, sp));
					f.push_back(makeUop(eof, sma, pc));
				end
				`OP_JRN:  f = jrFlow(inc, z);
				`OP_JRNZ: f = jrFlow(incEofZ, z);
				`OP_JRZ:  f = jrFlow(incEofNz, z);
				// Prefix hands over to the CB page
				`OP_CB:
				begin
					f.push_back(makeUop(inc, sma, pc));
					f.push_back(makeUop(op, nop, none));
					f.push_back(makeUop(inc, jcb, none));
				end
				default:  f.push_back(makeUop(incEof, z801bop, a));
			endcase
		end
		return f;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Checks and stimulus tasks
	//////////////////////////////////////////////////////////////////////

	task automatic failRun(input string msg);
		$display("%s", msg);
		$display("CHECKS FAILED");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic checkUop(input uopT got, input uopT exp, input string what);
		if (got !== exp)
			failRun($sformatf("error at %0t: %s got %s %s %s, expected %s %s %s", $time,
				what, got.endClass.name(), got.op.name(), got.operand.name(),
				exp.endClass.name(), exp.op.name(), exp.operand.name()));
	endtask

	task automatic checkEnd(input logic got, input logic exp, input string what);
		if (got !== exp)
			failRun($sformatf("error at %0t: %s is %b, expected %b", $time, what, got, exp));
	endtask

	// Called on a falling edge, returns on a falling edge
	task automatic sendOp(input logic [7:0] code, input logic z, input logic cb);
		uopQueueT flow;
		flow = expectFlow(cb, code, z);
		foreach (flow[i])
		begin
			expQ.push_back(flow[i]);
			lastQ.push_back(i == flow.size() - 1);
		end
		opcode   = code;
		zeroFlag = z;
		opValid  = 1'b1;
		do
			@(posedge Clock);
		while (!opReady);
		opsSent++;
		@(negedge Clock);
		opValid  = 1'b0;
		// Live Z after the take must not steer the flow
		zeroFlag = ~z;
	endtask

	task automatic sendPrefixed(input logic [7:0] code);
		sendOp(`OP_CB, 1'b0, 1'b0);
		sendOp(code, 1'b0, 1'b1);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Processes
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		Clock = 1'b0;
		forever
			#50 Clock = ~Clock;
	end

	// Limit grows with the traffic
	initial
	begin
		forever
		begin
			@(posedge Clock);
			cycles++;
			if (cycles > 40 * opsSent + 100)
				failRun($sformatf("Timeout after %0d cycles with %0d opcodes sent",
					cycles, opsSent));
		end
	end

	initial
	begin
		logic [31:0] rnd;
		forever
		begin
			@(negedge Clock);
			rnd = $random(seed);
			uopReady = randomReady ? rnd[0] : 1'b1;
		end
	end

	// Compare every consumed word, then the handshake one cycle later
	always @(posedge Clock)
	begin
		if (!rst)
		begin
			if (takePending)
			begin
				checkEnd(uopValid, 1'b1, "uopValid after a taken opcode");
				takePending = 1'b0;
			end
			if (endPending)
			begin
				checkEnd(opReady, endExpected, "opReady after a consumed word");
				checkEnd(uopValid, !endExpected, "uopValid after a consumed word");
				endPending = 1'b0;
			end
			if (u_dzcpuUcode.uChk.failCount != 0)
				failRun("A handshake assertion in the checker failed");
			if (opValid && opReady)
				takePending = 1'b1;
			if (uopValid && uopReady)
			begin
				if (expQ.size() == 0)
					failRun("The DUT produced a word that no flow expects");
				else
				begin
					checkUop(uop, expQ.pop_front(), "consumed word");
					endExpected = lastQ.pop_front();
					endPending  = 1'b1;
				end
			end
		end
	end

	initial
	begin
		rst      = 1'b1;
		opcode   = 8'h00;
		opValid  = 1'b0;
		zeroFlag = 1'b0;
		uopReady = 1'b1;
		repeat (4) @(posedge Clock);
		@(negedge Clock);
		rst = 1'b0;
		checkEnd(opReady, 1'b1, "opReady after reset");
		checkEnd(uopValid, 1'b0, "uopValid after reset");

		// Unused opcode runs the default flow
		sendOp(8'hD3, 1'b0, 1'b0);
		foreach (mainOps[i])
			sendOp(mainOps[i], 1'b0, 1'b0);

		// Both outcomes of each conditional jump
		sendOp(`OP_JRNZ, 1'b1, 1'b0);
		sendOp(`OP_JRZ, 1'b0, 1'b0);
		sendOp(`OP_JRNZ, 1'b0, 1'b0);
		sendOp(`OP_JRZ, 1'b1, 1'b0);
		sendOp(`OP_JRN, 1'b1, 1'b0);

		sendPrefixed(`CB_BIT7H);
		sendPrefixed(`CB_RLC);
		sendPrefixed(8'h37);

		// Same traffic under back-pressure
		randomReady = 1'b1;
		repeat (2)
		begin
			foreach (mainOps[i])
				sendOp(mainOps[i], i[0], 1'b0);
			sendPrefixed(`CB_BIT7H);
			sendPrefixed(`CB_RLC);
			sendPrefixed(8'h37);
		end

		while (expQ.size() != 0 || endPending || !opReady)
			@(negedge Clock);
		repeat (2) @(negedge Clock);
		if (expQ.size() == 0 && !uopValid && u_dzcpuUcode.uChk.failCount == 0)
		begin
			$display("ALL CHECKS PASSED");
			$finish;
		end
		else
			failRun("The DUT did not finish cleanly after the last opcode");
	end

endmodule
